/* Bender.yml */
package:
  name: uart_periph

sources:
  - src/uart_regs_pkg.sv
  - src/uart_frame_pkg.sv
  - src/uart_fifo.sv
  - src/uart_baud_gen.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart.sv
  - target: simulation
    files:
      - verification/uart_checker.sv
      - verification/uart_asserts.sv
      - verification/tb_uart.sv

/* src/uart.sv */
//////////////////////////////
// UART peripheral top level
// Bus FSM, registers, FIFOs
//////////////////////////////

`timescale 1ns/1ps

module uart #(
  parameter int clock_freq_hz = 10_000_000,
  parameter int baud_rate     = 115200,
  parameter int fifo_depth    = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        rd_en,
  input  logic        wr_en,
  input  logic [4:0]  addr,
  input  logic [31:0] wr_data,
  input  logic        rxd,
  output logic [31:0] rd_data,
  output logic        busy,
  output logic        txd
);

  localparam int div_width = uart_regs_pkg::div_width;
  localparam int cnt_width = uart_regs_pkg::cnt_width;
  localparam int cnt_lsb   = uart_regs_pkg::cnt_lsb;
  localparam int data_bits = uart_frame_pkg::data_bits;
  localparam logic [div_width-1:0] div_reset = div_width'(clock_freq_hz / baud_rate - 1);

  typedef enum logic [1:0] {
    bus_idle,
    bus_access,
    bus_hold
  } bus_state_t;

  bus_state_t            bus_state;
  logic                  is_read;
  logic [2:0]            reg_sel;
  logic [31:0]           wr_word;
  logic [31:0]           read_word;
  logic                  do_read;
  logic                  do_write;
  logic                  txen;
  logic                  nstop;
  logic [cnt_width-1:0]  txcnt;
  logic                  rxen;
  logic [cnt_width-1:0]  rxcnt;
  logic [1:0]            ie;
  logic [1:0]            ip;
  logic [div_width-1:0]  div;
  logic                  tx_tick;
  logic                  rx_tick;
  logic                  tx_push;
  logic                  tx_pop;
  logic                  tx_empty;
  logic                  tx_full;
  logic                  tx_below;
  uart_frame_pkg::byte_t tx_head;
  logic                  rx_push;
  logic                  rx_pop;
  logic                  rx_empty;
  logic                  rx_above;
  uart_frame_pkg::byte_t rx_head;
  uart_frame_pkg::byte_t rx_byte;

  // Idle -> Access -> Hold, strobes ignored while busy
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus_state <= bus_idle;
      is_read   <= 1'b0;
      reg_sel   <= '0;
    end else begin
      case (bus_state)
        bus_idle: begin
          if (rd_en || wr_en) begin
            bus_state <= bus_access;
            is_read   <= rd_en;
            reg_sel   <= addr[4:2];
          end
        end
        bus_access: bus_state <= bus_hold;
        default:    bus_state <= bus_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (bus_state == bus_idle && wr_en) begin
      wr_word <= wr_data;
    end
  end

  assign busy     = (bus_state != bus_idle);
  assign do_read  = (bus_state == bus_access) && is_read;
  assign do_write = (bus_state == bus_access) && !is_read;
  assign tx_push  = do_write && (reg_sel == uart_regs_pkg::reg_txdata);
  assign rx_pop   = do_read && (reg_sel == uart_regs_pkg::reg_rxdata) && !rx_empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txen  <= 1'b0;
      nstop <= 1'b0;
      txcnt <= '0;
      rxen  <= 1'b0;
      rxcnt <= '0;
      ie    <= '0;
      div   <= div_reset;
    end else if (do_write) begin
      case (reg_sel)
        uart_regs_pkg::reg_txctrl: begin
          txen  <= wr_word[uart_regs_pkg::en_bit];
          nstop <= wr_word[uart_regs_pkg::nstop_bit];
          txcnt <= wr_word[cnt_lsb +: cnt_width];
        end
        uart_regs_pkg::reg_rxctrl: begin
          rxen  <= wr_word[uart_regs_pkg::en_bit];
          rxcnt <= wr_word[cnt_lsb +: cnt_width];
        end
        uart_regs_pkg::reg_ie:  ie  <= wr_word[1:0];
        uart_regs_pkg::reg_div: div <= wr_word[div_width-1:0];
        default: begin
        end
      endcase
    end
  end

  // Pending bits track the watermark compares one cycle late
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ip <= '0;
    end else begin
      ip[uart_regs_pkg::txwm_bit] <= ie[uart_regs_pkg::txwm_bit] & tx_below;
      ip[uart_regs_pkg::rxwm_bit] <= ie[uart_regs_pkg::rxwm_bit] & rx_above;
    end
  end

  always_comb begin
    read_word = '0;
    case (reg_sel)
      uart_regs_pkg::reg_txdata: read_word[uart_regs_pkg::fifo_flag_bit] = tx_full;
      uart_regs_pkg::reg_rxdata: begin
        read_word[uart_regs_pkg::fifo_flag_bit] = rx_empty;
        if (!rx_empty) begin
          read_word[data_bits-1:0] = rx_head;
        end
      end
      uart_regs_pkg::reg_txctrl: begin
        read_word[uart_regs_pkg::en_bit]    = txen;
        read_word[uart_regs_pkg::nstop_bit] = nstop;
        read_word[cnt_lsb +: cnt_width]     = txcnt;
      end
      uart_regs_pkg::reg_rxctrl: begin
        read_word[uart_regs_pkg::en_bit] = rxen;
        read_word[cnt_lsb +: cnt_width]  = rxcnt;
      end
      uart_regs_pkg::reg_ie:  read_word[1:0] = ie;
      uart_regs_pkg::reg_ip:  read_word[1:0] = ip;
      uart_regs_pkg::reg_div: read_word[div_width-1:0] = div;
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
    end else if (do_read) begin
      rd_data <= read_word;
    end
  end

  uart_baud_gen i_baud_gen (
    .clock   (clock),
    .reset   (reset),
    .div     (div),
    .tx_tick (tx_tick),
    .rx_tick (rx_tick)
  );

  uart_fifo #(
    .depth (fifo_depth)
  ) i_tx_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (tx_push),
    .pop        (tx_pop),
    .wr_byte    (wr_word[data_bits-1:0]),
    .watermark  (txcnt),
    .head       (tx_head),
    .empty      (tx_empty),
    .full       (tx_full),
    .below_mark (tx_below),
    .above_mark ()
  );

  uart_tx i_tx (
    .clock      (clock),
    .reset      (reset),
    .tx_tick    (tx_tick),
    .txen       (txen),
    .nstop      (nstop),
    .fifo_empty (tx_empty),
    .head       (tx_head),
    .pop        (tx_pop),
    .txd        (txd)
  );

  uart_rx i_rx (
    .clock   (clock),
    .reset   (reset),
    .rx_tick (rx_tick),
    .rxen    (rxen),
    .nstop   (nstop),
    .rxd     (rxd),
    .push    (rx_push),
    .rx_byte (rx_byte)
  );

  uart_fifo #(
    .depth (fifo_depth)
  ) i_rx_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (rx_push),
    .pop        (rx_pop),
    .wr_byte    (rx_byte),
    .watermark  (rxcnt),
    .head       (rx_head),
    .empty      (rx_empty),
    .full       (),
    .below_mark (),
    .above_mark (rx_above)
  );

endmodule

/* src/uart_baud_gen.sv */
//////////////////////////////
// UART baud tick generator
// Bit rate and 16x rate enables
//////////////////////////////

`timescale 1ns/1ps

module uart_baud_gen (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [uart_regs_pkg::div_width-1:0] div,
  output logic                                 tx_tick,
  output logic                                 rx_tick
);

  localparam int div_width = uart_regs_pkg::div_width;
  localparam int shift     = $clog2(uart_frame_pkg::oversample);

  logic [div_width-1:0]       tx_cnt;
  logic [div_width-shift-1:0] rx_cnt;
  logic [div_width-shift-1:0] rx_div;

  // Receiver runs oversample times faster
  assign rx_div = div[div_width-1:shift];

  // Compare with >= so a smaller divisor takes effect at once
  assign tx_tick = (tx_cnt >= div);
  assign rx_tick = (rx_cnt >= rx_div);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_cnt <= '0;
      rx_cnt <= '0;
    end else begin
      tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
      rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
    end
  end

endmodule

/* src/uart_fifo.sv */
//////////////////////////////
// UART byte FIFO
// Circular buffer with fill
// count and watermark compare
//////////////////////////////

`timescale 1ns/1ps

module uart_fifo #(
  parameter int depth = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  uart_frame_pkg::byte_t wr_byte,
  input  logic [2:0]            watermark,
  output uart_frame_pkg::byte_t head,
  output logic                  empty,
  output logic                  full,
  output logic                  below_mark,
  output logic                  above_mark
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(depth - 1);

  uart_frame_pkg::byte_t mem [depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic [cnt_width-1:0]  mark;
  logic                  do_push;
  logic                  do_pop;

  // Overflow and underflow requests are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push != do_pop) begin
        count <= do_push ? count + 1'b1 : count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_byte;
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_width'(depth));

  // Same compare pair serves tx (below) and rx (above)
  assign mark       = cnt_width'(watermark);
  assign below_mark = (count < mark);
  assign above_mark = (count > mark);

endmodule

/* src/uart_frame_pkg.sv */
//////////////////////////////
// UART serial frame format
//////////////////////////////

package uart_frame_pkg;

  localparam int data_bits = 8;

  // Receiver ticks per bit time
  localparam int oversample = 16;

  // Tick within a bit where rxd is sampled
  localparam int sample_point = 8;

  typedef logic [data_bits-1:0] byte_t;

endpackage

/* src/uart_regs_pkg.sv */
//////////////////////////////
// UART register map
// Word indices, fields, widths
//////////////////////////////

package uart_regs_pkg;

  // Word index taken from addr[4:2]
  localparam logic [2:0] reg_txdata = 3'd0;
  localparam logic [2:0] reg_rxdata = 3'd1;
  localparam logic [2:0] reg_txctrl = 3'd2;
  localparam logic [2:0] reg_rxctrl = 3'd3;
  localparam logic [2:0] reg_ie     = 3'd4;
  localparam logic [2:0] reg_ip     = 3'd5;
  localparam logic [2:0] reg_div    = 3'd6;

  // Full flag on txdata, empty flag on rxdata
  localparam int fifo_flag_bit = 31;

  // txctrl and rxctrl fields
  localparam int en_bit    = 0;
  localparam int nstop_bit = 1;
  localparam int cnt_lsb   = 16;
  localparam int cnt_width = 3;

  // ie and ip fields
  localparam int txwm_bit = 0;
  localparam int rxwm_bit = 1;

  localparam int div_width = 16;

endpackage

/* src/uart_rx.sv */
//////////////////////////////
// UART receiver
// 16x sampling deserializer
//////////////////////////////

`timescale 1ns/1ps

module uart_rx (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rx_tick,
  input  logic                  rxen,
  input  logic                  nstop,
  input  logic                  rxd,
  output logic                  push,
  output uart_frame_pkg::byte_t rx_byte
);

  localparam int tick_width = $clog2(uart_frame_pkg::oversample);
  localparam int bit_width  = $clog2(uart_frame_pkg::data_bits);
  localparam logic [tick_width-1:0] mid_tick  = tick_width'(uart_frame_pkg::sample_point - 1);
  localparam logic [tick_width-1:0] last_tick = tick_width'(uart_frame_pkg::oversample - 1);
  localparam logic [bit_width-1:0]  last_bit  = bit_width'(uart_frame_pkg::data_bits - 1);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t             state;
  logic                  rxd_meta;
  logic                  rxd_sync;
  logic [tick_width-1:0] tick_cnt;
  logic [bit_width-1:0]  bit_cnt;
  logic                  second_stop;
  logic                  sample;
  uart_frame_pkg::byte_t shift_reg;

  // Two flop synchronizer, idles high
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // Middle of a data or stop bit
  assign sample = rx_tick && (tick_cnt == last_tick);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= rx_idle;
      tick_cnt    <= '0;
      bit_cnt     <= '0;
      second_stop <= 1'b0;
      push        <= 1'b0;
    end else begin
      push <= 1'b0;
      if (rx_tick) begin
        case (state)
          rx_idle: begin
            if (!rxd_sync) begin
              state    <= rx_start;
              tick_cnt <= '0;
            end
          end
          rx_start: begin
            // Confirm start at mid-bit, else treat as a glitch
            if (tick_cnt == mid_tick) begin
              tick_cnt <= '0;
              bit_cnt  <= '0;
              state    <= rxd_sync ? rx_idle : rx_data;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
          rx_data: begin
            tick_cnt <= tick_cnt + 1'b1;
            if (sample) begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == last_bit) begin
                state       <= rx_stop;
                second_stop <= 1'b0;
              end
            end
          end
          rx_stop: begin
            tick_cnt <= tick_cnt + 1'b1;
            if (sample) begin
              if (!second_stop) begin
                push <= rxen && rxd_sync;
              end
              if (nstop && !second_stop) begin
                second_stop <= 1'b1;
              end else begin
                state <= rx_idle;
              end
            end
          end
          default: state <= rx_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == rx_data && sample) begin
      shift_reg <= {rxd_sync, shift_reg[uart_frame_pkg::data_bits-1:1]};
    end
  end

  assign rx_byte = shift_reg;

endmodule

/* src/uart_tx.sv */
//////////////////////////////
// UART transmitter
// Pops bytes, drives txd frames
//////////////////////////////

`timescale 1ns/1ps

module uart_tx (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tx_tick,
  input  logic                  txen,
  input  logic                  nstop,
  input  logic                  fifo_empty,
  input  uart_frame_pkg::byte_t head,
  output logic                  pop,
  output logic                  txd
);

  localparam int bit_width = $clog2(uart_frame_pkg::data_bits);
  localparam logic [bit_width-1:0] last_bit = bit_width'(uart_frame_pkg::data_bits - 1);

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop1,
    tx_stop2
  } tx_state_t;

  tx_state_t             state;
  logic [bit_width-1:0]  bit_cnt;
  uart_frame_pkg::byte_t shift_reg;
  logic                  frame_done;
  logic                  load;

  assign frame_done = tx_tick && ((state == tx_stop1 && !nstop) || state == tx_stop2);

  // Next frame may follow the last stop bit directly
  assign load = tx_tick && txen && !fifo_empty && (state == tx_idle || frame_done);
  assign pop  = load;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= tx_idle;
      bit_cnt <= '0;
      txd     <= 1'b1;
    end else if (load) begin
      state <= tx_start;
      txd   <= 1'b0;
    end else if (tx_tick) begin
      case (state)
        tx_start: begin
          state   <= tx_data;
          bit_cnt <= '0;
          txd     <= shift_reg[0];
        end
        tx_data: begin
          if (bit_cnt == last_bit) begin
            state <= tx_stop1;
            txd   <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            txd     <= shift_reg[0];
          end
        end
        tx_stop1: state <= nstop ? tx_stop2 : tx_idle;
        tx_stop2: state <= tx_idle;
        default:  state <= tx_idle;
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clock) begin
    if (load) begin
      shift_reg <= head;
    end else if (tx_tick && (state == tx_start || state == tx_data)) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

/* uart_periph.f */
src/uart_regs_pkg.sv
src/uart_frame_pkg.sv
src/uart_fifo.sv
src/uart_baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
verification/uart_checker.sv
verification/uart_asserts.sv
verification/tb_uart.sv

/* verification/tb_uart.sv */
//////////////////////////////
// UART testbench
// Random bus and serial traffic
//////////////////////////////

`timescale 1ns/1ps

module tb_uart;

  // Sum of phase frame times with a factor of 2 margin
  localparam int cycle_limit = 200_000;

  logic        clock;
  logic        reset;
  logic        rd_en;
  logic        wr_en;
  logic [4:0]  addr;
  logic [31:0] wr_data;
  logic        rxd;
  logic [31:0] rd_data;
  logic        busy;
  logic        txd;
  integer      seed = 32'h494dd06d;
  int          cycles = 0;
  int          tb_errors = 0;
  int          cur_div = 15;
  int          total;

  uart #(
    .clock_freq_hz (10_000_000),
    .baud_rate     (625000),
    .fifo_depth    (8)
  ) i_uart (
    .clock   (clock),
    .reset   (reset),
    .rd_en   (rd_en),
    .wr_en   (wr_en),
    .addr    (addr),
    .wr_data (wr_data),
    .rxd     (rxd),
    .rd_data (rd_data),
    .busy    (busy),
    .txd     (txd)
  );

  uart_checker i_check (
    .clock   (clock),
    .reset   (reset),
    .rd_en   (rd_en),
    .wr_en   (wr_en),
    .addr    (addr),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .busy    (busy),
    .txd     (txd),
    .rxd     (rxd)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // One strobe, then wait for busy to drop
  task automatic bus_op(input bit read, input logic [2:0] idx, input logic [31:0] data);
    int n;
    @(negedge clock);
    rd_en   = read;
    wr_en   = !read;
    addr    = {idx, 2'b00};
    wr_data = data;
    @(negedge clock);
    rd_en = 1'b0;
    wr_en = 1'b0;
    n = 0;
    while (busy) begin
      n++;
      @(negedge clock);
    end
    if (n != 2) begin
      tb_errors++;
      $display("Error %s: busy cycles expected 2, actual %0d", i_check.test_name, n);
    end
  endtask

  task automatic bus_write(input logic [2:0] idx, input logic [31:0] data);
    if (idx == uart_regs_pkg::reg_div) cur_div = data[15:0];
    bus_op(1'b0, idx, data);
  endtask

  task automatic bus_read(input logic [2:0] idx);
    bus_op(1'b1, idx, 32'd0);
  endtask

  task automatic send_frame(input logic [7:0] b, input bit two_stop);
    logic [11:0] bits;
    bits = {2'b11, 1'b1, b, 1'b0};
    for (int i = 0; i < (two_stop ? 11 : 10); i++) begin
      @(negedge clock);
      rxd = bits[i];
      repeat (cur_div) @(negedge clock);
    end
  endtask

  task automatic wait_tx_drain();
    while (i_check.tx_q.size() != 0 || i_check.tx_active) @(negedge clock);
    repeat (2 * (cur_div + 1)) @(negedge clock);
  endtask

  task automatic setup_line(output bit nst);
    nst = rand_below(2);
    bus_write(uart_regs_pkg::reg_div, rand_below(2) ? 32'd15 : 32'd31);
    bus_write(uart_regs_pkg::reg_txctrl, {30'd0, nst, 1'b0});
  endtask

  initial begin
    bit          nst;
    int          n;
    int          m;
    logic [2:0]  idx;
    logic [31:0] txc;
    rd_en = 1'b0;
    wr_en = 1'b0;
    addr = '0;
    wr_data = '0;
    rxd = 1'b1;
    reset = 1'b1;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    i_check.test_name = "reset";
    for (int r = 0; r < 7; r++) bus_read(r);

    i_check.test_name = "registers";
    for (int k = 0; k < 12; k++) begin
      idx = 3'd2 + rand_below(3);
      if (idx == 3'd4 && rand_below(2)) idx = uart_regs_pkg::reg_div;
      bus_write(idx, $random(seed));
      bus_read(idx);
    end
    bus_write(uart_regs_pkg::reg_div, 32'd15);
    bus_write(uart_regs_pkg::reg_txctrl, 32'd0);
    bus_write(uart_regs_pkg::reg_rxctrl, 32'd0);

    i_check.test_name = "transmit";
    for (int r = 0; r < 3; r++) begin
      setup_line(nst);
      n = 1 + rand_below(10);
      for (int k = 0; k < n; k++) bus_write(uart_regs_pkg::reg_txdata, $random(seed));
      bus_read(uart_regs_pkg::reg_txdata);
      bus_write(uart_regs_pkg::reg_txctrl, {30'd0, nst, 1'b1});
      wait_tx_drain();
      bus_write(uart_regs_pkg::reg_txctrl, {30'd0, nst, 1'b0});
    end

    i_check.test_name = "receive";
    for (int r = 0; r < 2; r++) begin
      setup_line(nst);
      bus_write(uart_regs_pkg::reg_rxctrl, 32'd1);
      n = 1 + rand_below(10);
      for (int k = 0; k < n; k++) send_frame($random(seed), nst);
      repeat (2 * (cur_div + 1)) @(negedge clock);
      for (int k = 0; k <= n; k++) bus_read(uart_regs_pkg::reg_rxdata);
      bus_write(uart_regs_pkg::reg_rxctrl, 32'd0);
      send_frame($random(seed), nst);
      repeat (2 * (cur_div + 1)) @(negedge clock);
      bus_write(uart_regs_pkg::reg_rxctrl, 32'd1);
      bus_read(uart_regs_pkg::reg_rxdata);
    end

    i_check.test_name = "watermark";
    for (int r = 0; r < 4; r++) begin
      bus_write(uart_regs_pkg::reg_div, 32'd15);
      txc = {13'd0, 3'(rand_below(8)), 16'd0};
      bus_write(uart_regs_pkg::reg_txctrl, txc);
      bus_write(uart_regs_pkg::reg_rxctrl, {13'd0, 3'(rand_below(8)), 16'd1});
      bus_write(uart_regs_pkg::reg_ie, rand_below(4));
      n = rand_below(9);
      m = rand_below(9);
      for (int k = 0; k < n; k++) bus_write(uart_regs_pkg::reg_txdata, $random(seed));
      for (int k = 0; k < m; k++) send_frame($random(seed), 1'b0);
      repeat (2 * (cur_div + 1)) @(negedge clock);
      bus_read(uart_regs_pkg::reg_ip);
      for (int k = 0; k <= m; k++) bus_read(uart_regs_pkg::reg_rxdata);
      bus_write(uart_regs_pkg::reg_txctrl, txc | 32'd1);
      wait_tx_drain();
      bus_write(uart_regs_pkg::reg_txctrl, txc);
    end

    total = i_check.errors + tb_errors + i_uart.i_asserts.fails;
    $display("Run finished: %0d errors (%0d model, %0d bus timing, %0d assertion)",
             total, i_check.errors, tb_errors, i_uart.i_asserts.fails);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verification/uart_asserts.sv */
//////////////////////////////
// UART protocol assertions
// Bus timing, FIFO, txd idle
//////////////////////////////

`timescale 1ns/1ps

module uart_asserts #(
  parameter int depth = 8
) (
  input logic        clock,
  input logic        reset,
  input logic        rd_en,
  input logic        wr_en,
  input logic        busy,
  input logic        txd,
  input logic        txen,
  input logic        tx_push,
  input logic        tx_pop,
  input logic        rx_push,
  input logic        rx_pop,
  input logic [31:0] rd_data
);

  int   fails = 0;
  logic txen_seen;
  int   tx_fill;
  int   rx_fill;

  function automatic int next_fill(input int fill, input logic push, input logic pop);
    int n;
    n = fill;
    if (push && fill < depth) n++;
    if (pop && fill > 0) n--;
    return n;
  endfunction

  always @(posedge clock or posedge reset) begin
    if (reset) begin
      txen_seen <= 1'b0;
    end else if (txen) begin
      txen_seen <= 1'b1;
    end
  end

  // Fill levels counted from the push and pop strobes alone
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_fill <= 0;
      rx_fill <= 0;
    end else begin
      tx_fill <= next_fill(tx_fill, tx_push, tx_pop);
      rx_fill <= next_fill(rx_fill, rx_push, rx_pop);
    end
  end

  // Accepted strobe gives exactly two busy cycles
  busy_length: assert property (@(posedge clock) disable iff (reset)
    (!busy && (rd_en || wr_en)) |=> busy ##1 busy ##1 !busy)
    else begin
      fails++;
      $error("busy did not last exactly 2 cycles after a strobe");
    end

  txd_idle: assert property (@(posedge clock) disable iff (reset) !txen_seen |-> txd)
    else begin
      fails++;
      $error("txd left idle before the transmitter was enabled");
    end

  tx_pop_safe: assert property (@(posedge clock) disable iff (reset) tx_pop |-> tx_fill != 0)
    else begin
      fails++;
      $error("tx FIFO popped while empty");
    end

  rx_pop_safe: assert property (@(posedge clock) disable iff (reset) rx_pop |-> rx_fill != 0)
    else begin
      fails++;
      $error("rx FIFO popped while empty");
    end

  rd_data_hold: assert property (@(posedge clock) disable iff (reset)
    (!busy && $past(!busy)) |-> $stable(rd_data))
    else begin
      fails++;
      $error("rd_data changed while the bus was idle");
    end

endmodule

bind uart uart_asserts #(
  .depth (fifo_depth)
) i_asserts (
  .clock   (clock),
  .reset   (reset),
  .rd_en   (rd_en),
  .wr_en   (wr_en),
  .busy    (busy),
  .txd     (txd),
  .txen    (txen),
  .tx_push (tx_push),
  .tx_pop  (tx_pop),
  .rx_push (rx_push),
  .rx_pop  (rx_pop),
  .rd_data (rd_data)
);

/* verification/uart_checker.sv */
//////////////////////////////
// UART reference model
// Registers, FIFOs and frames
//////////////////////////////

`timescale 1ns/1ps

module uart_checker (
  input logic        clock,
  input logic        reset,
  input logic        rd_en,
  input logic        wr_en,
  input logic [4:0]  addr,
  input logic [31:0] wr_data,
  input logic [31:0] rd_data,
  input logic        busy,
  input logic        txd,
  input logic        rxd
);

  int    errors = 0;
  string test_name = "none";

  logic                  txen;
  logic                  nstop;
  logic                  rxen;
  logic [2:0]            txcnt;
  logic [2:0]            rxcnt;
  logic [1:0]            ie;
  logic [15:0]           div;
  uart_frame_pkg::byte_t tx_q[$];
  uart_frame_pkg::byte_t rx_q[$];
  logic                  tx_active = 1'b0;
  logic                  pend;
  logic [31:0]           exp_word;

  // txd changes on rising edges, rxd on falling edges
  function automatic logic line(input bit which);
    return which ? rxd : txd;
  endfunction

  task automatic step(input bit which);
    if (which) begin
      @(posedge clock);
    end else begin
      @(negedge clock);
    end
  endtask

  // Called just after the start edge, samples each bit at its middle
  task automatic decode_frame(input bit which, output uart_frame_pkg::byte_t data,
                              output bit ok);
    int p;
    p = div + 1;
    ok = 1'b1;
    data = '0;
    repeat (p / 2) step(which);
    if (line(which) !== 1'b0) ok = 1'b0;
    for (int i = 0; i < 8; i++) begin
      repeat (p) step(which);
      data[i] = line(which);
    end
    repeat (p) step(which);
    if (line(which) !== 1'b1) ok = 1'b0;
    if (nstop) begin
      repeat (p) step(which);
      if (line(which) !== 1'b1) ok = 1'b0;
    end
  endtask

  task automatic report(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
    errors++;
    $display("Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic model_read(input logic [2:0] sel);
    exp_word = '0;
    case (sel)
      uart_regs_pkg::reg_txdata: exp_word[31] = (tx_q.size() >= 8);
      uart_regs_pkg::reg_rxdata: begin
        if (rx_q.size() == 0) exp_word[31] = 1'b1;
        else exp_word[7:0] = rx_q.pop_front();
      end
      uart_regs_pkg::reg_txctrl: exp_word = {13'd0, txcnt, 14'd0, nstop, txen};
      uart_regs_pkg::reg_rxctrl: exp_word = {13'd0, rxcnt, 15'd0, rxen};
      uart_regs_pkg::reg_ie:     exp_word = {30'd0, ie};
      uart_regs_pkg::reg_ip: begin
        exp_word[1] = ie[1] && (rx_q.size() > rxcnt);
        exp_word[0] = ie[0] && (tx_q.size() < txcnt);
      end
      uart_regs_pkg::reg_div:    exp_word = {16'd0, div};
      default:                   exp_word = '0;
    endcase
  endtask

  task automatic model_write(input logic [2:0] sel, input logic [31:0] d);
    case (sel)
      uart_regs_pkg::reg_txdata: if (tx_q.size() < 8) tx_q.push_back(d[7:0]);
      uart_regs_pkg::reg_txctrl: begin
        txen  = d[0];
        nstop = d[1];
        txcnt = d[18:16];
      end
      uart_regs_pkg::reg_rxctrl: begin
        rxen  = d[0];
        rxcnt = d[18:16];
      end
      uart_regs_pkg::reg_ie:  ie = d[1:0];
      uart_regs_pkg::reg_div: div = d[15:0];
      default: begin
      end
    endcase
  endtask

  always @(posedge clock or posedge reset) begin
    if (reset) begin
      {txen, nstop, rxen, txcnt, rxcnt, ie} = '0;
      div = 16'd15;
      pend = 1'b0;
      tx_q.delete();
      rx_q.delete();
    end else if (!busy && (rd_en || wr_en)) begin
      if (rd_en) begin
        model_read(addr[4:2]);
        pend = 1'b1;
      end else begin
        model_write(addr[4:2], wr_data);
      end
    end
  end

  always @(negedge clock) begin
    if (pend && !busy) begin
      pend = 1'b0;
      if (rd_data !== exp_word) report("read data", exp_word, rd_data);
    end
  end

  always begin : tx_watch
    logic                  prev;
    bit                    has;
    bit                    ok;
    uart_frame_pkg::byte_t expb;
    uart_frame_pkg::byte_t b;
    prev = txd;
    step(1'b0);
    if (!reset && prev === 1'b1 && txd === 1'b0) begin
      tx_active = 1'b1;
      has = (tx_q.size() != 0);
      if (has) expb = tx_q.pop_front();
      decode_frame(1'b0, b, ok);
      if (!has) begin
        errors++;
        $display("A frame started on txd while the model FIFO was empty");
      end else if (!ok) begin
        errors++;
        $display("Bad start or stop bit in a txd frame during %s", test_name);
      end else if (b !== expb) begin
        report("txd byte", expb, b);
      end
      tx_active = 1'b0;
    end
  end

  always begin : rx_watch
    logic                  prev;
    bit                    ok;
    uart_frame_pkg::byte_t b;
    prev = rxd;
    step(1'b1);
    if (!reset && prev === 1'b1 && rxd === 1'b0) begin
      decode_frame(1'b1, b, ok);
      // Bytes beyond a full FIFO are lost
      if (ok && rxen && rx_q.size() < 8) rx_q.push_back(b);
    end
  end

endmodule
